/* hw/soc_settings.svh */
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// sram windows, 4 MB each
`define BASE_LO 32'h8000_0000
`define BASE_HI 32'h803F_FFFF
`define EXT_LO  32'h8040_0000
`define EXT_HI  32'h807F_FFFF

// boot rom, word addressed
`define ROM_DEPTH 64
`define ROM_LO    32'h1FC0_0000
`define ROM_HI    (`ROM_LO + `ROM_DEPTH * 4 - 1)

// serial port registers
`define UART_DATA_ADDR 32'hBFD0_03F8
`define UART_STAT_ADDR 32'hBFD0_03FC

`define BAUD_DIV 16  // clocks per serial bit

`endif

/* hw/bus_pkg.sv */
package bus_pkg;

    typedef struct packed {
        logic [8:0]  unused;
        logic        bank;    // base or ext
        logic [19:0] word;    // goes straight to the sram pins
        logic [1:0]  offset;
    } sram_addr_t;

    typedef struct packed {
        logic [3:0]  segment;
        logic [25:0] index;
        logic [1:0]  offset;
    } rom_addr_t;

    // same address word, seen by sram or rom
    typedef union packed {
        sram_addr_t sram;
        rom_addr_t  rom;
    } bus_addr_u;

    typedef struct packed {
        logic        read;
        logic        write;
        bus_addr_u   addr;
        logic [31:0] wdata;
        logic [3:0]  mask;    // byte enables, active high
    } bus_req_t;

    typedef struct packed {
        logic [19:0] addr;
        logic [3:0]  be_n;
        logic        ce_n;
        logic        oe_n;
        logic        we_n;
        logic [31:0] wdata;
        logic        drive;   // data bus enable
    } sram_pins_t;

endpackage

/* hw/periph_pkg.sv */
package periph_pkg;

    // target of one bus access
    typedef enum logic [2:0] {
        NONE,
        BASE,
        EXT,
        ROM,
        UART_DATA,
        UART_STAT
    } region_e;

    typedef struct packed {
        logic [30:0] zero;
        logic        tx_idle;
    } uart_status_t;

endpackage

/* hw/addr_decode.sv */
`include "soc_settings.svh"

module addr_decode (
    input  bus_pkg::bus_addr_u  addr_i,
    input  logic                active_i,
    output periph_pkg::region_e region_o
);

    logic [31:0] addr;

    assign addr = addr_i;  // flat view for window compares

    always_comb begin
        region_o = periph_pkg::NONE;
        if (active_i) begin
            if (addr >= `BASE_LO && addr <= `BASE_HI) begin
                region_o = periph_pkg::BASE;
            end else if (addr >= `EXT_LO && addr <= `EXT_HI) begin
                region_o = periph_pkg::EXT;
            end else if (addr >= `ROM_LO && addr <= `ROM_HI) begin
                region_o = periph_pkg::ROM;
            end else if (addr == `UART_DATA_ADDR) begin
                region_o = periph_pkg::UART_DATA;
            end else if (addr == `UART_STAT_ADDR) begin
                region_o = periph_pkg::UART_STAT;
            end
        end
    end

endmodule

/* hw/sram_controller.sv */
module sram_controller (
    input  logic                clk_25M,
    input  logic                rst_i,
    input  bus_pkg::bus_req_t   pri_i,
    input  bus_pkg::bus_req_t   sec_i,
    output logic [31:0]         pri_rdata_o,
    output logic [31:0]         sec_rdata_o,
    output logic                stall_o,
    output bus_pkg::sram_pins_t pins_o,
    input  logic [31:0]         rdata_i
);

    typedef enum logic [2:0] {IDLE, PRI_SETUP, PRI_STROBE, SEC_SETUP, SEC_STROBE} state_e;

    state_e            state_q, state_d;
    bus_pkg::bus_req_t cur;
    logic              pri_act, sec_act, strobe;
    logic [31:0]       pri_q, sec_q;

    assign pri_act = pri_i.read | pri_i.write;
    assign sec_act = sec_i.read | sec_i.write;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (pri_act) begin
                    state_d = PRI_SETUP;
                end else if (sec_act) begin
                    state_d = SEC_SETUP;
                end
            end
            PRI_SETUP:  state_d = PRI_STROBE;
            PRI_STROBE: state_d = sec_act ? SEC_SETUP : IDLE;
            SEC_SETUP:  state_d = SEC_STROBE;
            default:    state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_25M) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // released only in the last strobe
    assign stall_o = (state_q == IDLE && (pri_act || sec_act)) || state_q == PRI_SETUP ||
                     state_q == SEC_SETUP || (state_q == PRI_STROBE && sec_act);

    assign cur    = (state_q == SEC_SETUP || state_q == SEC_STROBE) ? sec_i : pri_i;
    assign strobe = state_q == PRI_STROBE || state_q == SEC_STROBE;

    always_comb begin
        pins_o.addr  = cur.addr.sram.word;
        pins_o.be_n  = ~cur.mask;
        pins_o.ce_n  = state_q == IDLE;
        pins_o.oe_n  = !(strobe && cur.read);
        pins_o.we_n  = !(strobe && cur.write);
        pins_o.wdata = cur.wdata;
        pins_o.drive = state_q != IDLE && cur.write;  // setup and strobe
    end

    // pri word held while sec is served
    always_ff @(posedge clk_25M) begin
        if (state_q == PRI_STROBE && pri_i.read) begin
            pri_q <= rdata_i;
        end
        if (state_q == SEC_STROBE && sec_i.read) begin
            sec_q <= rdata_i;
        end
    end

    assign pri_rdata_o = (state_q == PRI_STROBE) ? rdata_i : pri_q;
    assign sec_rdata_o = (state_q == SEC_STROBE) ? rdata_i : sec_q;

endmodule

/* hw/bootrom.sv */
`include "soc_settings.svh"

module bootrom (
    input  logic               clk_25M,
    input  logic               rst_i,
    input  logic               ia_re_i,
    input  bus_pkg::bus_addr_u ia_addr_i,
    input  logic               da_re_i,
    input  bus_pkg::bus_addr_u da_addr_i,
    output logic [31:0]        ia_rdata_o,
    output logic [31:0]        da_rdata_o,
    output logic               stall_o
);

    localparam int IDX_W = $clog2(`ROM_DEPTH);

    logic [31:0]        mem [`ROM_DEPTH];
    bus_pkg::bus_addr_u ia_addr_q, da_addr_q;
    logic               ia_vld_q, da_vld_q;
    logic               ia_hit, da_hit;

    initial $readmemh("hw/bootrom.hex", mem);

    always_ff @(posedge clk_25M) begin
        if (rst_i) begin
            ia_vld_q <= 1'b0;
            da_vld_q <= 1'b0;
        end else begin
            ia_vld_q <= ia_re_i;
            da_vld_q <= da_re_i;
        end
    end

    always_ff @(posedge clk_25M) begin
        if (ia_re_i) begin
            ia_addr_q  <= ia_addr_i;
            ia_rdata_o <= mem[ia_addr_i.rom.index[IDX_W-1:0]];
        end
        if (da_re_i) begin
            da_addr_q  <= da_addr_i;
            da_rdata_o <= mem[da_addr_i.rom.index[IDX_W-1:0]];
        end
    end

    // word already fetched for the held address
    assign ia_hit  = ia_vld_q && ia_addr_q == ia_addr_i;
    assign da_hit  = da_vld_q && da_addr_q == da_addr_i;
    assign stall_o = (ia_re_i && !ia_hit) || (da_re_i && !da_hit);

endmodule

/* hw/uart_tx.sv */
`include "soc_settings.svh"

module uart_tx (
    input  logic                     clk_25M,
    input  logic                     rst_i,
    input  logic                     we_i,
    input  logic [7:0]               wbyte_i,
    output periph_pkg::uart_status_t status_o,
    output logic                     stall_o,
    output logic                     txd_o
);

    localparam int BAUD_W = $clog2(`BAUD_DIV);

    logic [9:0]        shift_q;   // stop, data, start
    logic [3:0]        bits_q;    // bits left in frame
    logic [BAUD_W-1:0] baud_q;
    logic              busy;

    assign busy = bits_q != 4'd0;

    always_ff @(posedge clk_25M) begin
        if (rst_i) begin
            shift_q <= '1;
            bits_q  <= 4'd0;
            baud_q  <= '0;
        end else if (!busy) begin
            if (we_i) begin
                shift_q <= {1'b1, wbyte_i, 1'b0};
                bits_q  <= 4'd10;
                baud_q  <= '0;
            end
        end else if (baud_q == BAUD_W'(`BAUD_DIV - 1)) begin
            baud_q  <= '0;
            shift_q <= {1'b1, shift_q[9:1]};  // line idles high
            bits_q  <= bits_q - 4'd1;
        end else begin
            baud_q <= baud_q + 1'b1;
        end
    end

    assign txd_o            = shift_q[0];
    assign stall_o          = we_i && busy;  // back-pressure on a full transmitter
    assign status_o.zero    = '0;
    assign status_o.tx_idle = !busy;

endmodule

/* hw/bus_router.sv */
module bus_router (
    input  logic                clk_25M,
    input  logic                rst_i,
    input  logic                inst_ce_i,
    input  bus_pkg::bus_addr_u  inst_addr_i,
    input  bus_pkg::bus_req_t   data_req_i,
    output logic                stall_o,
    output logic [31:0]         inst_rdata_o,
    output logic [31:0]         data_rdata_o,
    output bus_pkg::sram_pins_t base_pins_o,
    input  logic [31:0]         base_rdata_i,
    output bus_pkg::sram_pins_t ext_pins_o,
    input  logic [31:0]         ext_rdata_i,
    output logic                txd_o
);

    periph_pkg::region_e      inst_reg, data_reg;
    periph_pkg::uart_status_t uart_status;
    bus_pkg::bus_req_t        inst_req, base_pri, base_sec, ext_pri, ext_sec;
    logic [31:0]              base_pri_rd, base_sec_rd, ext_pri_rd, ext_sec_rd;
    logic [31:0]              rom_ia_rd, rom_da_rd;
    logic                     base_stall, ext_stall, rom_stall, uart_stall, uart_we;
    logic                     inst_base, inst_ext, data_base, data_ext;

    // fetch is a full word read
    assign inst_req = '{read: inst_ce_i, write: 1'b0, addr: inst_addr_i, wdata: '0, mask: 4'hF};

    addr_decode u_inst_dec (.addr_i(inst_addr_i), .active_i(inst_ce_i), .region_o(inst_reg));
    addr_decode u_data_dec (
        .addr_i(data_req_i.addr),
        .active_i(data_req_i.read | data_req_i.write),
        .region_o(data_reg)
    );

    assign inst_base = inst_reg == periph_pkg::BASE;
    assign inst_ext  = inst_reg == periph_pkg::EXT;
    assign data_base = data_reg == periph_pkg::BASE;
    assign data_ext  = data_reg == periph_pkg::EXT;

    // data goes to sec only when fetch owns the same bank
    always_comb begin
        base_pri = inst_base ? inst_req : '0;
        ext_pri  = inst_ext ? inst_req : '0;
        base_sec = '0;
        ext_sec  = '0;
        if (data_base) begin
            if (inst_base) begin
                base_sec = data_req_i;
            end else begin
                base_pri = data_req_i;
            end
        end
        if (data_ext) begin
            if (inst_ext) begin
                ext_sec = data_req_i;
            end else begin
                ext_pri = data_req_i;
            end
        end
    end

    sram_controller u_base (
        .clk_25M, .rst_i, .pri_i(base_pri), .sec_i(base_sec), .pri_rdata_o(base_pri_rd),
        .sec_rdata_o(base_sec_rd), .stall_o(base_stall), .pins_o(base_pins_o),
        .rdata_i(base_rdata_i)
    );

    sram_controller u_ext (
        .clk_25M, .rst_i, .pri_i(ext_pri), .sec_i(ext_sec), .pri_rdata_o(ext_pri_rd),
        .sec_rdata_o(ext_sec_rd), .stall_o(ext_stall), .pins_o(ext_pins_o),
        .rdata_i(ext_rdata_i)
    );

    // rom writes dropped
    bootrom u_rom (
        .clk_25M, .rst_i, .ia_re_i(inst_reg == periph_pkg::ROM), .ia_addr_i(inst_addr_i),
        .da_re_i(data_reg == periph_pkg::ROM && data_req_i.read), .da_addr_i(data_req_i.addr),
        .ia_rdata_o(rom_ia_rd), .da_rdata_o(rom_da_rd), .stall_o(rom_stall)
    );

    // send once, after the other targets have let go
    assign uart_we = data_reg == periph_pkg::UART_DATA && data_req_i.write &&
                     !(base_stall || ext_stall || rom_stall);

    uart_tx u_uart (
        .clk_25M, .rst_i, .we_i(uart_we), .wbyte_i(data_req_i.wdata[7:0]),
        .status_o(uart_status), .stall_o(uart_stall), .txd_o
    );

    assign stall_o = base_stall | ext_stall | rom_stall | uart_stall;

    always_comb begin
        case (inst_reg)
            periph_pkg::BASE: inst_rdata_o = base_pri_rd;
            periph_pkg::EXT:  inst_rdata_o = ext_pri_rd;
            periph_pkg::ROM:  inst_rdata_o = rom_ia_rd;
            default:          inst_rdata_o = '0;
        endcase
        case (data_reg)
            periph_pkg::BASE:      data_rdata_o = inst_base ? base_sec_rd : base_pri_rd;
            periph_pkg::EXT:       data_rdata_o = inst_ext ? ext_sec_rd : ext_pri_rd;
            periph_pkg::ROM:       data_rdata_o = rom_da_rd;
            periph_pkg::UART_STAT: data_rdata_o = uart_status;
            default:               data_rdata_o = '0;  // unmapped, or no receiver
        endcase
    end

endmodule

/* hw/mem_bus_top.sv */
module mem_bus_top (
    input  logic                clk_25M,
    input  logic                rst_i,
    input  logic                inst_ce_i,
    input  bus_pkg::bus_addr_u  inst_addr_i,
    input  bus_pkg::bus_req_t   data_req_i,
    output logic                stall_o,
    output logic [31:0]         inst_rdata_o,
    output logic [31:0]         data_rdata_o,
    output bus_pkg::sram_pins_t base_pins_o,
    input  logic [31:0]         base_rdata_i,
    output bus_pkg::sram_pins_t ext_pins_o,
    input  logic [31:0]         ext_rdata_i,
    output logic                txd_o
);

    // cpu side ports to sram banks, boot rom and serial port
    bus_router u_router (
        .clk_25M      (clk_25M),
        .rst_i        (rst_i),
        .inst_ce_i    (inst_ce_i),
        .inst_addr_i  (inst_addr_i),
        .data_req_i   (data_req_i),
        .stall_o      (stall_o),
        .inst_rdata_o (inst_rdata_o),
        .data_rdata_o (data_rdata_o),
        .base_pins_o  (base_pins_o),
        .base_rdata_i (base_rdata_i),
        .ext_pins_o   (ext_pins_o),
        .ext_rdata_i  (ext_rdata_i),
        .txd_o        (txd_o)
    );

endmodule

/* test/tb_mem_bus.sv */
`include "soc_settings.svh"

// asynchronous sram bank, one word per address
module sram_model #(
    parameter logic [11:0] FILL_TAG = 12'h000
) (
    input  logic                clk_25M,
    input  bus_pkg::sram_pins_t pins_i,
    output logic [31:0]         rdata_o
);

    logic [31:0] mem [0:(1 << 20) - 1];

    initial begin
        for (int i = 0; i < (1 << 20); i++) begin
            mem[i] = {FILL_TAG, i[19:0]};  // tag plus word index
        end
    end

    always @(posedge clk_25M) begin
        if (!pins_i.ce_n && !pins_i.we_n && pins_i.drive) begin
            for (int b = 0; b < 4; b++) begin
                if (!pins_i.be_n[b]) begin
                    mem[pins_i.addr][8*b +: 8] = pins_i.wdata[8*b +: 8];
                end
            end
        end
    end

    assign rdata_o = (!pins_i.ce_n && !pins_i.oe_n) ? mem[pins_i.addr] : 32'h0;

endmodule

module tb_mem_bus;

    localparam int WAIT_LIMIT = 1000;

    logic                clk_25M = 1'b0;
    logic                rst, inst_ce, stall, txd;
    bus_pkg::bus_addr_u  inst_addr;
    bus_pkg::bus_req_t   data_req;
    logic [31:0]         inst_rdata, data_rdata, base_rdata, ext_rdata;
    bus_pkg::sram_pins_t base_pins, ext_pins;
    int                  cycle = 0;

    mem_bus_top UUT (
        .clk_25M      (clk_25M),
        .rst_i        (rst),
        .inst_ce_i    (inst_ce),
        .inst_addr_i  (inst_addr),
        .data_req_i   (data_req),
        .stall_o      (stall),
        .inst_rdata_o (inst_rdata),
        .data_rdata_o (data_rdata),
        .base_pins_o  (base_pins),
        .base_rdata_i (base_rdata),
        .ext_pins_o   (ext_pins),
        .ext_rdata_i  (ext_rdata),
        .txd_o        (txd)
    );

    sram_model #(.FILL_TAG(12'hBA5)) u_base_mem (.clk_25M, .pins_i(base_pins), .rdata_o(base_rdata));
    sram_model #(.FILL_TAG(12'hE7A)) u_ext_mem (.clk_25M, .pins_i(ext_pins), .rdata_o(ext_rdata));

    always #50 clk_25M = ~clk_25M;

    always @(posedge clk_25M) cycle <= cycle + 1;  // read at negedge only

    task automatic fail_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("error at time %0t: %s, got %h, expected %h", $time, what, got, expected);
            fail_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        fail_run();
    endtask

    task automatic drive_request(input logic ce, input logic [31:0] ia, input logic rd,
                                 input logic wr, input logic [31:0] da,
                                 input logic [31:0] wd, input logic [3:0] mask);
        @(posedge clk_25M);
        #10;
        inst_ce        = ce;
        inst_addr      = ia;
        data_req.read  = rd;
        data_req.write = wr;
        data_req.addr  = da;
        data_req.wdata = wd;
        data_req.mask  = mask;
    endtask

    task automatic drive_idle();
        drive_request(1'b0, 32'h0, 1'b0, 1'b0, 32'h0, 32'h0, 4'h0);
    endtask

    // cycles from request until stall_o drops
    task automatic wait_for_release(output int lat);
        lat = 0;
        @(negedge clk_25M);
        while (stall) begin
            lat++;
            if (lat > WAIT_LIMIT) report_timeout("stall_o to drop");
            @(negedge clk_25M);
        end
    endtask

    function automatic int bank_of(input logic [31:0] a);
        if (a >= `BASE_LO && a <= `BASE_HI) return 0;
        if (a >= `EXT_LO && a <= `EXT_HI) return 1;
        return -1;
    endfunction

    function automatic logic in_rom(input logic [31:0] a);
        return a >= `ROM_LO && a <= `ROM_HI;
    endfunction

    // slowest target wins, shared bank serves twice
    function automatic int expected_latency(input logic ce, input logic [31:0] ia,
                                            input logic rd, input logic wr,
                                            input logic [31:0] da);
        int ib;
        int db;
        ib = ce ? bank_of(ia) : -1;
        db = (rd || wr) ? bank_of(da) : -1;
        if (ib >= 0 && ib == db) return 4;
        if (ib >= 0 || db >= 0) return 2;
        if ((ce && in_rom(ia)) || (rd && in_rom(da))) return 1;
        return 0;
    endfunction

    task automatic run_access(input logic [15:0] op, input logic [31:0] ia,
                              input logic [31:0] da, input logic [31:0] wd,
                              input logic [3:0] mask, input logic [31:0] exp_inst,
                              input logic [31:0] exp_data);
        logic ce, rd, wr;
        int   lat;
        ce = op == "ft";
        rd = op == "rd" || op == "ft";
        wr = op == "wr";
        if (!ce && !rd && !wr) begin
            $display("unknown opcode in stimulus file");
            fail_run();
        end
        drive_request(ce, ia, rd, wr, da, wd, mask);
        wait_for_release(lat);
        check_value(lat, expected_latency(ce, ia, rd, wr, da), "cycles until stall_o low");
        if (ce) check_value(inst_rdata, exp_inst, "instruction word");
        if (rd) check_value(data_rdata, exp_data, "data word");
        drive_idle();
    endtask

    task automatic read_status(input logic [31:0] expected);
        int lat;
        drive_request(1'b0, 32'h0, 1'b1, 1'b0, `UART_STAT_ADDR, 32'h0, 4'hF);
        wait_for_release(lat);
        check_value(lat, 0, "status read latency");
        check_value(data_rdata, expected, "serial status word");
        drive_idle();
    endtask

    // samples mid-bit, returns at mid stop bit
    task automatic decode_frame(input logic [7:0] value);
        int waited;
        waited = 0;
        @(negedge clk_25M);
        while (txd) begin
            waited++;
            if (waited > 4 * `BAUD_DIV) report_timeout("start bit on txd_o");
            @(negedge clk_25M);
        end
        repeat (`BAUD_DIV / 2) @(negedge clk_25M);
        check_value(32'(txd), 32'd0, "start bit");
        for (int i = 0; i < 8; i++) begin
            repeat (`BAUD_DIV) @(negedge clk_25M);
            check_value(32'(txd), 32'(value[i]), "data bit");
        end
        repeat (`BAUD_DIV) @(negedge clk_25M);
        check_value(32'(txd), 32'd1, "stop bit");
    endtask

    task automatic run_serial(input logic [31:0] da, input logic [7:0] first,
                              input logic [7:0] second);
        int lat;
        int t_first;
        drive_request(1'b0, 32'h0, 1'b0, 1'b1, da, {24'h0, first}, 4'h1);
        wait_for_release(lat);
        check_value(lat, 0, "serial write to idle transmitter");
        t_first = cycle;
        drive_idle();
        decode_frame(first);
        read_status(32'h0);  // stop bit still on the line
        drive_request(1'b0, 32'h0, 1'b0, 1'b1, da, {24'h0, second}, 4'h1);
        wait_for_release(lat);
        check_value(cycle, t_first + 10 * `BAUD_DIV + 1, "cycle of held serial write");
        drive_idle();
        decode_frame(second);
        repeat (`BAUD_DIV) @(negedge clk_25M);
        read_status(32'h1);
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [15:0] op;
        logic [31:0] ia, da, wd, exp_inst, exp_data;
        logic [3:0]  mask;
        rst       = 1'b1;
        inst_ce   = 1'b0;
        inst_addr = '0;
        data_req  = '0;
        repeat (10) @(posedge clk_25M);
        #10;
        rst = 1'b0;
        @(negedge clk_25M);
        check_value(32'(stall), 32'd0, "stall_o after reset");
        check_value(32'({base_pins.ce_n, base_pins.oe_n, base_pins.we_n, base_pins.drive}),
                    32'hE, "base strobes and drive after reset");
        check_value(32'({ext_pins.ce_n, ext_pins.oe_n, ext_pins.we_n, ext_pins.drive}),
                    32'hE, "ext strobes and drive after reset");
        check_value(32'(txd), 32'd1, "txd_o after reset");

        fd = $fopen("test/mem_bus_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open test/mem_bus_stimulus.txt");
            fail_run();
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h", op, ia, da, wd, mask,
                            exp_inst, exp_data);
                if (n != 7) begin
                    $display("malformed stimulus line: %s", line);
                    fail_run();
                end
                if (op == "tx") begin
                    run_serial(da, wd[7:0], wd[15:8]);
                end else begin
                    run_access(op, ia, da, wd, mask, exp_inst, exp_data);
                end
            end
        end
        $fclose(fd);
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hw
hw/bus_pkg.sv
hw/periph_pkg.sv
hw/addr_decode.sv
hw/sram_controller.sv
hw/bootrom.sv
hw/uart_tx.sv
hw/bus_router.sv
hw/mem_bus_top.sv
test/tb_mem_bus.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -f flist.f --top-module tb_mem_bus -o sim_mem_bus
./obj_dir/sim_mem_bus 2>&1 | tee sim.log
if grep -q "PASS: all tests" sim.log; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed"
    exit 1
fi

/* hw/bootrom.hex */
// one 32-bit instruction word per line, from word 0
3C088000
25080100
8D090000
01095021
3C0ABFD0
254A03F8
AD490000
1000FFFF

/* test/mem_bus_stimulus.txt */
# op inst_addr data_addr wdata mask exp_inst exp_data, all hex
# wr data write, rd data read, ft fetch plus data read, tx sends wdata[7:0] then wdata[15:8]
wr 00000000 80000100 11223344 3 00000000 00000000
rd 00000000 80000100 00000000 f 00000000 ba503344
wr 00000000 80400200 aabbccdd c 00000000 00000000
rd 00000000 80400200 00000000 f 00000000 aabb0080
wr 00000000 80000104 deadbeef f 00000000 00000000
wr 00000000 80000104 00000055 2 00000000 00000000
rd 00000000 80000104 00000000 f 00000000 dead00ef
ft 1fc00000 80000100 00000000 f 3c088000 ba503344
ft 1fc00004 80400200 00000000 f 25080100 aabb0080
ft 1fc00008 80000104 00000000 f 8d090000 dead00ef
ft 1fc0000c 00000000 00000000 f 01095021 00000000
ft 80000104 80000100 00000000 f dead00ef ba503344
ft 80400200 80400204 00000000 f aabb0080 e7a00081
ft 80000100 80400200 00000000 f ba503344 aabb0080
rd 00000000 00001000 00000000 f 00000000 00000000
tx 00000000 bfd003f8 0000a53c 1 00000000 00000000
